/* rtl/fsm_lab_consts.svh */
`ifndef FSM_LAB_CONSTS_SVH
`define FSM_LAB_CONSTS_SVH

// slow strobe that clocks bits into the led shift register.
`define FSM_LAB_SHIFT_STROBE_WIDTH 23

// display scan strobe, one digit per pulse.
`define FSM_LAB_DISPLAY_STROBE_WIDTH 10

// stable cycles before a key level is accepted.
`define FSM_LAB_DEBOUNCE_DEPTH 8

// pattern both detectors look for, first bit in the msb.
`define FSM_LAB_PATTERN 4'b1101

`endif

/* rtl/fsm_pkg.sv */
package fsm_pkg;

    // moore states, named by the tail of the pattern seen so far.
    typedef enum logic [2:0] {
        MOORE_IDLE  = 3'd0, // nothing useful seen.
        MOORE_S1    = 3'd1, // "1".
        MOORE_S11   = 3'd2, // "11".
        MOORE_S110  = 3'd3, // "110".
        MOORE_S1101 = 3'd4  // full match, output high.
    } moore_state_t;

    // mealy needs one state less, the match is on the transition.
    typedef enum logic [1:0] {
        MEALY_IDLE = 2'd0,
        MEALY_S1   = 2'd1,
        MEALY_S11  = 2'd2,
        MEALY_S110 = 2'd3
    } mealy_state_t;

    // detector outputs side by side.
    typedef struct packed {
        logic moore; // level, whole strobe period.
        logic mealy; // only during the enable cycle.
    } detect_hits_t;

endpackage

/* rtl/display_pkg.sv */
package display_pkg;

    // word shown on the four digits, leftmost digit is the top nibble.
    typedef struct packed {
        logic [7:0] strobe_count; // digits 3 and 2.
        logic [3:0] moore_count;  // digit 1.
        logic [3:0] mealy_count;  // digit 0.
    } display_word_t;

    // board side of the seven segment display.
    // segments and anodes are both active low.
    typedef struct packed {
        logic [7:0] abcdefgh; // a in the msb, h is the dot.
        logic [3:0] digit;    // one anode per digit, bit n is digit n.
    } segment_bus_t;

    // all dark, no digit selected.
    localparam segment_bus_t SEGMENT_BUS_OFF = '{
        abcdefgh: 8'hff,
        digit:    4'hf
    };

    // value held on the display after reset.
    localparam display_word_t DISPLAY_WORD_ZERO = '{
        strobe_count: 8'h00,
        moore_count:  4'h0,
        mealy_count:  4'h0
    };

endpackage

/* rtl/key_sampler.sv */
`timescale 1ns/100ps

module key_sampler #(
    parameter int depth = 8 // cycles a synced level must hold.
) (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_en,        // shift strobe.
    input  logic [3:0] i_key_sw,    // raw keys, active low.
    output logic [3:0] o_shift_reg  // register contents, bit 3 newest.
);

    localparam int cnt_w = $clog2(depth + 1);

    logic [3:0]       sync_q1;        // first synchronizer stage.
    logic [3:0]       sync_q2;        // second stage, safe to use.
    logic [3:0]       key_db;         // debounced, pressed reads 1.
    logic [cnt_w-1:0] stable_cnt [4]; // cycles of disagreement per key.
    logic [3:0]       shift_q;

    // keys are inverted here so that a press is a 1 downstream.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= ~i_key_sw;
            sync_q2 <= sync_q1;
        end
    end

    // a key flips only after depth cycles of a different synced level.
    // any bounce back to the old level restarts the count.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            key_db <= '0;
            for (int k = 0; k < 4; k++) stable_cnt[k] <= '0;
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (sync_q2[k] == key_db[k]) begin
                    stable_cnt[k] <= '0;                // agrees, nothing pending.
                end else if (stable_cnt[k] == cnt_w'(depth - 1)) begin
                    key_db[k]     <= sync_q2[k];        // held long enough.
                    stable_cnt[k] <= '0;
                end else begin
                    stable_cnt[k] <= stable_cnt[k] + 1'b1;
                end
            end
        end
    end

    // key 1 enters at the top, register moves right.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) shift_q <= '0;
        else if (i_en) shift_q <= {key_db[1], shift_q[3:1]};
    end

    assign o_shift_reg = shift_q;

endmodule

/* rtl/strobe_gen.sv */
`timescale 1ns/100ps

module strobe_gen #(
    parameter int width = 23 // period is 2**width clocks.
) (
    input  logic clk,
    input  logic i_arst_n,
    output logic o_strobe // one cycle high per period.
);

    logic [width-1:0] cnt;

    // free running, wraps on its own.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt      <= '0;
            o_strobe <= 1'b0;
        end else begin
            cnt      <= cnt + 1'b1;
            o_strobe <= &cnt; // high the cycle after all ones.
        end
    end

    // first pulse 2**width clocks after reset release.

endmodule

/* rtl/moore_detector.sv */
`timescale 1ns/100ps

`include "fsm_lab_consts.svh"

module moore_detector
    import fsm_pkg::*;
(
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_en,  // advance on the shift strobe only.
    input  logic i_bit, // oldest bit of the shift register.
    output logic o_hit  // held for a whole strobe period.
);

    localparam logic [3:0] pattern = `FSM_LAB_PATTERN;

    moore_state_t state;
    moore_state_t state_next;

    // forward steps follow the pattern bits.
    // fallback steps are the overlap of 1101 with itself.
    always_comb begin
        state_next = state;
        case (state)
            MOORE_IDLE:  state_next = (i_bit == pattern[3]) ? MOORE_S1 : MOORE_IDLE;
            MOORE_S1:    state_next = (i_bit == pattern[2]) ? MOORE_S11 : MOORE_IDLE;
            MOORE_S11:   state_next = (i_bit == pattern[1]) ? MOORE_S110 : MOORE_S11;
            MOORE_S110:  state_next = (i_bit == pattern[0]) ? MOORE_S1101 : MOORE_IDLE;
            // last 1 of a match plus a new 1 gives "11".
            MOORE_S1101: state_next = i_bit ? MOORE_S11 : MOORE_IDLE;
            default:     state_next = MOORE_IDLE; // unused codes recover.
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= MOORE_IDLE;
        end else if (i_en) begin
            state <= state_next;
        end
    end

    // output from the state alone.
    assign o_hit = (state == MOORE_S1101);

    // lags the mealy output by one strobe for the same match.

endmodule

/* rtl/mealy_detector.sv */
`timescale 1ns/100ps

`include "fsm_lab_consts.svh"

module mealy_detector
    import fsm_pkg::*;
(
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_en,  // shift strobe.
    input  logic i_bit, // oldest bit of the shift register.
    output logic o_hit  // single cycle, on the matching strobe.
);

    localparam logic [3:0] pattern = `FSM_LAB_PATTERN;

    mealy_state_t state;
    mealy_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            MEALY_IDLE: state_next = (i_bit == pattern[3]) ? MEALY_S1 : MEALY_IDLE;
            MEALY_S1:   state_next = (i_bit == pattern[2]) ? MEALY_S11 : MEALY_IDLE;
            MEALY_S11:  state_next = (i_bit == pattern[1]) ? MEALY_S110 : MEALY_S11;
            // a match leaves "1" behind for the next one.
            MEALY_S110: state_next = (i_bit == pattern[0]) ? MEALY_S1 : MEALY_IDLE;
            default:    state_next = MEALY_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) state <= MEALY_IDLE;
        else if (i_en) state <= state_next;
    end

    // depends on the input, so it leads the moore hit by a strobe.
    assign o_hit = i_en && (state == MEALY_S110) && (i_bit == pattern[0]);

endmodule

/* rtl/detect_tally.sv */
`timescale 1ns/100ps

module detect_tally
    import fsm_pkg::*;
    import display_pkg::*;
(
    input  logic          clk,
    input  logic          i_arst_n,
    input  logic          i_en,   // shift strobe.
    input  detect_hits_t  i_hits, // both detector outputs.
    output display_word_t o_word  // goes straight to the display.
);

    logic [7:0] strobe_count;
    logic [3:0] moore_count;
    logic [3:0] mealy_count;

    // all three wrap silently.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            strobe_count <= '0;
            moore_count  <= '0;
            mealy_count  <= '0;
        end else if (i_en) begin
            strobe_count <= strobe_count + 1'b1; // every strobe.
            // moore level lasts the whole period, sampled once here.
            if (i_hits.moore) moore_count <= moore_count + 1'b1;
            // mealy pulse is already gated by the strobe.
            if (i_hits.mealy) mealy_count <= mealy_count + 1'b1;
        end
    end

    // strobe count on the two left digits.
    always_comb begin
        o_word              = DISPLAY_WORD_ZERO;
        o_word.strobe_count = strobe_count;
        o_word.moore_count  = moore_count;
        o_word.mealy_count  = mealy_count;
    end

endmodule

/* rtl/seven_segment_driver.sv */
`timescale 1ns/100ps

module seven_segment_driver
    import display_pkg::*;
(
    input  logic          clk,
    input  logic          i_arst_n,
    input  logic          i_en,   // display strobe, one digit per pulse.
    input  display_word_t i_word,
    output segment_bus_t  o_seg   // to the board pins.
);

    logic [1:0]   index;     // digit being lit.
    logic [15:0]  word_bits;
    logic [3:0]   nibble;
    segment_bus_t seg_next;
    segment_bus_t seg_q;

    // active high a to g, a in the msb.
    function automatic logic [6:0] hex_to_seg(input logic [3:0] value);
        case (value)
            4'h0:    hex_to_seg = 7'b1111110;
            4'h1:    hex_to_seg = 7'b0110000;
            4'h2:    hex_to_seg = 7'b1101101;
            4'h3:    hex_to_seg = 7'b1111001;
            4'h4:    hex_to_seg = 7'b0110011;
            4'h5:    hex_to_seg = 7'b1011011;
            4'h6:    hex_to_seg = 7'b1011111;
            4'h7:    hex_to_seg = 7'b1110000;
            4'h8:    hex_to_seg = 7'b1111111;
            4'h9:    hex_to_seg = 7'b1111011;
            4'ha:    hex_to_seg = 7'b1110111;
            4'hb:    hex_to_seg = 7'b0011111; // lower case b.
            4'hc:    hex_to_seg = 7'b1001110;
            4'hd:    hex_to_seg = 7'b0111101; // lower case d.
            4'he:    hex_to_seg = 7'b1001111;
            default: hex_to_seg = 7'b1000111; // f.
        endcase
    endfunction

    // scan 0, 1, 2, 3 and around.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) index <= '0;
        else if (i_en) index <= index + 1'b1;
    end

    assign word_bits = i_word;
    assign nibble    = word_bits[index*4 +: 4]; // digit n shows nibble n.

    always_comb begin
        seg_next          = SEGMENT_BUS_OFF;
        seg_next.abcdefgh = {~hex_to_seg(nibble), 1'b1}; // dot stays dark.
        seg_next.digit    = ~(4'b0001 << index);
    end

    // one cycle behind the index. reset shows 0 on digit 0.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) seg_q <= '{abcdefgh: 8'b0000_0011, digit: 4'b1110};
        else           seg_q <= seg_next;
    end

    assign o_seg = seg_q;

endmodule

/* rtl/fsm_lab_top.sv */
`timescale 1ns/100ps

`include "fsm_lab_consts.svh"

module fsm_lab_top
    import fsm_pkg::*;
    import display_pkg::*;
#(
    parameter int shift_strobe_width   = `FSM_LAB_SHIFT_STROBE_WIDTH,
    parameter int display_strobe_width = `FSM_LAB_DISPLAY_STROBE_WIDTH,
    parameter int debounce_depth       = `FSM_LAB_DEBOUNCE_DEPTH
) (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic [3:0] i_key_sw,   // pressed reads 0.
    output logic [3:0] o_led,      // active low.
    output logic [7:0] o_abcdefgh, // active low, dot in bit 0.
    output logic [3:0] o_digit     // active low anodes.
);

    logic          shift_strobe;   // slow, paces the bit stream.
    logic          display_strobe; // fast, paces the digit scan.
    logic [3:0]    shift_reg;
    detect_hits_t  hits;
    display_word_t word;
    segment_bus_t  seg;

    strobe_gen #(.width(shift_strobe_width)) shift_strobe_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .o_strobe (shift_strobe)
    );

    strobe_gen #(.width(display_strobe_width)) display_strobe_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .o_strobe (display_strobe)
    );

    key_sampler #(.depth(debounce_depth)) key_sampler_inst (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_en        (shift_strobe),
        .i_key_sw    (i_key_sw),
        .o_shift_reg (shift_reg)
    );

    assign o_led = ~shift_reg; // lit led is a 1 bit.

    // both detectors read the bit about to leave the register.
    moore_detector moore_detector_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_en     (shift_strobe),
        .i_bit    (shift_reg[0]),
        .o_hit    (hits.moore)
    );

    mealy_detector mealy_detector_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_en     (shift_strobe),
        .i_bit    (shift_reg[0]),
        .o_hit    (hits.mealy)
    );

    detect_tally detect_tally_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_en     (shift_strobe),
        .i_hits   (hits),
        .o_word   (word)
    );

    seven_segment_driver seven_segment_driver_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_en     (display_strobe),
        .i_word   (word),
        .o_seg    (seg)
    );

    assign o_abcdefgh = seg.abcdefgh;
    assign o_digit    = seg.digit;

endmodule

/* testbench/fsm_lab_tb.sv */
`timescale 1ns/100ps

module fsm_lab_tb;

    localparam int    strobe_period = 128; // 2**7 clocks per shift strobe.
    localparam int    feed_offset   = 3;   // update edge is +1, keys move two later.
    localparam int    drive_delay   = 10;
    localparam int    wait_limit    = 400;
    localparam int    scan_limit    = 64;  // a full scan takes 16 clocks.
    localparam string test_file     = "testbench/fsm_lab_tests.txt";

    logic       clk;
    logic       i_arst_n;
    logic [3:0] i_key_sw;
    logic [3:0] o_led;
    logic [7:0] o_abcdefgh;
    logic [3:0] o_digit;

    int         cycle_count = 0; // clocks since reset release.
    int         fed;             // strobes that have a bit assigned.
    logic [3:0] exp_reg;         // model of the led shift register.

    fsm_lab_top #(
        .shift_strobe_width   (7),
        .display_strobe_width (2),
        .debounce_depth       (4)
    ) fsm_lab_top_inst (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_key_sw   (i_key_sw),
        .o_led      (o_led),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (i_arst_n) cycle_count <= cycle_count + 1;
    end

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    // leaves the caller drive_delay after a rising edge.
    task automatic wait_for_cycle(input int target);
        int waited;
        waited = 0;
        while (cycle_count < target) begin
            @(posedge clk);
            #(drive_delay);
            waited++;
            if (waited > wait_limit) begin
                $display("Timeout: clock %0d not reached after %0d clocks", target, waited);
                stop_with_failure();
            end
        end
    endtask

    // active low a to g, dot high in bit 0.
    function automatic logic [7:0] hex_pattern(input logic [3:0] value);
        case (value)
            4'h0:    return 8'h03;
            4'h1:    return 8'h9f;
            4'h2:    return 8'h25;
            4'h3:    return 8'h0d;
            4'h4:    return 8'h99;
            4'h5:    return 8'h49;
            4'h6:    return 8'h41;
            4'h7:    return 8'h1f;
            4'h8:    return 8'h01;
            4'h9:    return 8'h09;
            4'ha:    return 8'h11;
            4'hb:    return 8'hc1; // lower case.
            4'hc:    return 8'h63;
            4'hd:    return 8'h85; // lower case.
            4'he:    return 8'h61;
            default: return 8'h71;
        endcase
    endfunction

    // msb set when the pattern is a known digit.
    function automatic logic [4:0] decode_segments(input logic [7:0] pattern);
        logic [4:0] result;
        result = 5'b0_0000;
        for (int v = 0; v < 16; v++) begin
            if (hex_pattern(4'(v)) == pattern) result = {1'b1, 4'(v)};
        end
        return result;
    endfunction

    function automatic int anode_index(input logic [3:0] digit);
        case (digit)
            4'b1110: return 0;
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return -1; // none or several lit.
        endcase
    endfunction

    // key 1 set two clocks after the previous strobe, checked leds first.
    task automatic feed_bit(input logic b);
        logic [3:0] exp_led;
        wait_for_cycle(strobe_period * fed + feed_offset);
        exp_led = ~exp_reg;
        check_value("led pattern", 16'(o_led), 16'(exp_led));
        i_key_sw[1] = ~b; // a pressed key reads 0.
        exp_reg = {b, exp_reg[3:1]};
        fed++;
    endtask

    // collects all four digits of one scan, then compares the fields.
    task automatic check_display(input logic [15:0] expected);
        logic [3:0] seen;
        logic [3:0] shown [4];
        logic [4:0] decoded;
        int         idx;
        int         waited;
        seen   = 4'h0;
        waited = 0;
        wait_for_cycle(strobe_period * fed + feed_offset);
        while (seen != 4'hf) begin
            idx = anode_index(o_digit);
            decoded = decode_segments(o_abcdefgh);
            if (idx < 0) begin
                $display("Anodes %b do not select exactly one digit", o_digit);
                stop_with_failure();
            end
            if (!decoded[4]) begin
                $display("Segment pattern %b on digit %0d is no hex digit", o_abcdefgh, idx);
                stop_with_failure();
            end
            shown[idx] = decoded[3:0];
            seen[idx]  = 1'b1;
            if (seen != 4'hf) begin
                @(posedge clk);
                #(drive_delay);
                waited++;
                if (waited > scan_limit) begin
                    $display("Timeout: digits %b never lit during the scan", ~seen);
                    stop_with_failure();
                end
            end
        end
        check_value("strobe count", 16'({shown[3], shown[2]}), 16'(expected[15:8]));
        check_value("moore count", 16'(shown[1]), 16'(expected[7:4]));
        check_value("mealy count", 16'(shown[0]), 16'(expected[3:0]));
    endtask

    task automatic run_line(input string line);
        byte         kind;
        int          fields;
        int          nbits;
        logic [31:0] bits;
        logic [7:0]  exp_strobe;
        logic [3:0]  exp_moore;
        logic [3:0]  exp_mealy;
        kind = line.getc(0);
        if (kind == "B") begin
            fields = $sscanf(line, "B %d %b", nbits, bits);
            if (fields != 2 || nbits < 1 || nbits > 32) begin
                $display("Malformed bit line in test file: %s", line);
                stop_with_failure();
            end
            for (int i = nbits - 1; i >= 0; i--) feed_bit(bits[i]); // leftmost first.
        end else if (kind == "C") begin
            fields = $sscanf(line, "C %h %h %h", exp_strobe, exp_moore, exp_mealy);
            if (fields != 3) begin
                $display("Malformed count line in test file: %s", line);
                stop_with_failure();
            end
            check_display({exp_strobe, exp_moore, exp_mealy});
        end else if (kind != "#" && kind != 8'd10 && kind != 8'd13 && kind != 8'd0) begin
            $display("Unknown line in test file: %s", line);
            stop_with_failure();
        end
    endtask

    initial begin
        string line;
        int    fd;
        int    got;
        i_arst_n = 1'b0;
        i_key_sw = 4'hf; // nothing pressed.
        exp_reg  = 4'h0;
        fed      = 0;
        repeat (16) @(posedge clk);
        #(drive_delay);
        i_arst_n = 1'b1;
        fd = $fopen(test_file, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", test_file);
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 0) run_line(line);
        end
        $fclose(fd);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* testbench/fsm_lab_tests.txt */
# B <count> <bits>: bits fed on key 1, one per shift strobe, leftmost first.
# C <strobes> <moore> <mealy>: expected hex counts on the display.
# display right after reset.
C 00 0 0
# two overlapping matches, mealy one strobe ahead of moore.
B 7 1101101
B 1 0
C 08 0 1
B 3 000
C 0b 1 2
B 1 0
C 0c 2 2
# no match in 1001 or 111, strobes still counted.
B 4 1001
B 3 111
B 5 00000
C 18 2 2
# fourteen more matches, both hit counts wrap.
B 1 1
B 21 101101101101101101101
B 21 101101101101101101101
B 4 0000
C 47 f 0
B 1 0
C 48 0 0
# counting goes on after the wrap.
B 4 1101
B 5 00000
C 51 1 1

/* compile.f */
+incdir+rtl
rtl/fsm_pkg.sv
rtl/display_pkg.sv
rtl/key_sampler.sv
rtl/strobe_gen.sv
rtl/moore_detector.sv
rtl/mealy_detector.sv
rtl/detect_tally.sv
rtl/seven_segment_driver.sv
rtl/fsm_lab_top.sv
testbench/fsm_lab_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/100ps
TOP       ?= fsm_lab_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
